//--- files.f
+incdir+test
source/rvIsaPkg.sv
source/cpuCtrlPkg.sv
source/aluUnit.sv
source/immGenerator.sv
source/registerFile.sv
source/instrMemory.sv
source/dataMemory.sv
source/multiCycleControl.sv
source/multiCycleCore.sv
test/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it, check the log
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary -Wno-fatal --top-module coreTb -f files.f --Mdir "$buildDir" -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/coreSim" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

//--- source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import rvIsaPkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpE           op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [shamtW-1:0] shamt;

    assign shamt = b[shamtW-1:0];

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: result = {{(xlen-1){1'b0}}, a < b};
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt; // Sign bit fills from the left
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);                  // Used by BEQ after SUB

endmodule

`default_nettype wire

//--- source/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;
    import rvIsaPkg::*;

    typedef enum logic [1:0] {
        stFetch,
        stDecode,
        stExecute,
        stWriteback
    } ctrlStateE;

    typedef enum logic {
        srcPc,
        srcRs1
    } srcASelE;

    typedef enum logic [1:0] {
        srcRs2,
        srcImm,
        srcFour
    } srcBSelE;

    typedef enum logic [1:0] {
        immI,
        immS,
        immB
    } immKindE;

    typedef struct packed {
        logic    pcWrite;
        logic    pcBranch;                         // PC takes the latched ALU result
        logic    irWrite;
        srcASelE srcA;
        srcBSelE srcB;
        aluOpE   aluOp;
        immKindE immKind;
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
        logic    retire;
        logic    illegal;
    } ctrlWordT;

    localparam ctrlWordT ctrlNop = '{
        pcWrite:  1'b0,
        pcBranch: 1'b0,
        irWrite:  1'b0,
        srcA:     srcRs1,
        srcB:     srcRs2,
        aluOp:    aluAdd,
        immKind:  immI,
        regWrite: 1'b0,
        memWrite: 1'b0,
        memToReg: 1'b0,
        retire:   1'b0,
        illegal:  1'b0
    };

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;                   // Zero when nothing is written
        logic [xlen-1:0]     data;
        logic [xlen-1:0]     count;
        logic                illegal;
    } retireT;

endpackage

`default_nettype wire

//--- source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import rvIsaPkg::*;
(
    input  logic            clk,
    input  logic            we,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0]      mem [dmemWords];
    logic [dmemAddrW-1:0] wordAddr;

    assign wordAddr = addr[dmemAddrW+1:2];         // Drop the byte offset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordAddr] <= wdata;
        end
    end

    assign rdata = mem[wordAddr];

endmodule

`default_nettype wire

//--- source/immGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module immGenerator
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  instrFieldsT     instr,
    input  immKindE         kind,
    output logic [xlen-1:0] imm
);

    logic signBit;

    assign signBit = instr.funct7[6];              // Instruction bit 31

    always_comb begin
        case (kind)
            immS: imm = {{(xlen-12){signBit}}, instr.funct7, instr.rd};
            immB: imm = {{(xlen-13){signBit}}, signBit, instr.rd[0],
                         instr.funct7[5:0], instr.rd[4:1], 1'b0};
            default: imm = {{(xlen-12){signBit}}, instr.funct7, instr.rs2};
        endcase
    end

endmodule

`default_nettype wire

//--- source/instrMemory.sv
`timescale 1ns/1ps
`default_nettype none

module instrMemory
    import rvIsaPkg::*;
(
    input  logic                 clk,
    input  logic                 we,
    input  logic [imemAddrW-1:0] waddr,
    input  logic [xlen-1:0]      wdata,
    input  logic [xlen-1:0]      raddr,
    output logic [xlen-1:0]      rdata
);

    logic [xlen-1:0]      mem [imemWords];
    logic [imemAddrW-1:0] wordAddr;

    assign wordAddr = raddr[imemAddrW+1:2];        // Byte PC to word index

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[wordAddr];

endmodule

`default_nettype wire

//--- source/multiCycleControl.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        run,
    input  instrFieldsT instr,
    input  logic        zero,
    output ctrlWordT    ctrl
);

    ctrlStateE state;
    ctrlStateE stateNext;
    aluOpE     decOp;
    logic      legal;
    logic      isReg;
    logic      isImm;
    logic      isLoad;
    logic      isStore;
    logic      isBranch;

    function automatic aluOpE aluFromFunct3(input logic [2:0] funct3);
        aluOpE op;
        case (funct3)
            f3Sll:   op = aluSll;
            f3Slt:   op = aluSlt;
            f3Sltu:  op = aluSltu;
            f3Xor:   op = aluXor;
            f3Srl:   op = aluSrl;
            f3Or:    op = aluOr;
            f3And:   op = aluAnd;
            default: op = aluAdd;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        case (state)
            stFetch:     stateNext = run ? stDecode : stFetch; // Hold here while stopped
            stDecode:    stateNext = stExecute;
            stExecute:   stateNext = stWriteback;
            default:     stateNext = stFetch;
        endcase
    end

    // Instruction class and ALU operation of the latched instruction
    always_comb begin
        decOp    = aluAdd;
        legal    = 1'b0;
        isReg    = 1'b0;
        isImm    = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        case (instr.opcode)
            opReg: begin
                isReg = 1'b1;
                legal = 1'b1;
                if (instr.funct7 == funct7Base) begin
                    decOp = aluFromFunct3(instr.funct3);
                end else if (instr.funct7 == funct7Alt && instr.funct3 == f3AddSub) begin
                    decOp = aluSub;
                end else if (instr.funct7 == funct7Alt && instr.funct3 == f3Srl) begin
                    decOp = aluSra;
                end else begin
                    legal = 1'b0;
                end
            end
            opImm: begin
                isImm = 1'b1;
                legal = 1'b1;
                decOp = aluFromFunct3(instr.funct3);
                if (instr.funct3 == f3Sll && instr.funct7 != funct7Base) begin
                    legal = 1'b0;
                end
                if (instr.funct3 == f3Srl && instr.funct7 == funct7Alt) begin
                    decOp = aluSra;                // SRAI
                end else if (instr.funct3 == f3Srl && instr.funct7 != funct7Base) begin
                    legal = 1'b0;
                end
            end
            opLoad: begin
                isLoad = (instr.funct3 == f3Word);
                legal  = isLoad;
            end
            opStore: begin
                isStore = (instr.funct3 == f3Word);
                legal   = isStore;
            end
            opBranch: begin
                isBranch = (instr.funct3 == f3Beq);
                legal    = isBranch;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl         = ctrlNop;
        ctrl.immKind = isStore ? immS : (isBranch ? immB : immI);
        case (state)
            stFetch: begin
                ctrl.pcWrite = run;                // PC + 4 through the ALU
                ctrl.irWrite = run;
                ctrl.srcA    = srcPc;
                ctrl.srcB    = srcFour;
            end
            stExecute: begin
                ctrl.aluOp = decOp;
                ctrl.srcB  = isReg ? srcRs2 : srcImm;
                if (isBranch) begin
                    ctrl.srcA  = srcPc;            // Branch target goes to the result register
                    ctrl.aluOp = aluAdd;
                end
            end
            stWriteback: begin
                ctrl.retire   = 1'b1;
                ctrl.illegal  = !legal;
                ctrl.regWrite = legal && (isReg || isImm || isLoad);
                ctrl.memWrite = isStore;
                ctrl.memToReg = isLoad;
                if (isBranch) begin
                    ctrl.aluOp    = aluSub;        // Compare rs1 with rs2
                    ctrl.pcWrite  = zero;
                    ctrl.pcBranch = 1'b1;
                end
            end
            default: begin
                ctrl.irWrite = 1'b0;               // Decode only captures operands
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/multiCycleCore.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleCore
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 loadEn,
    input  logic [imemAddrW-1:0] loadAddr,
    input  logic [xlen-1:0]      loadData,
    output logic                 retireValid,
    output retireT               retire
);

    ctrlWordT        ctrl;
    instrFieldsT     ir;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instrPc;                      // Address of the instruction in flight
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] imemRdata;
    logic [xlen-1:0] dmemRdata;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pcOperand;
    logic [xlen-1:0] aluA;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] wbData;
    logic [xlen-1:0] retireCount;
    logic            aluZero;
    logic            decodeQ;
    logic            executeQ;

    multiCycleControl control_i (
        .clk   (clk),
        .arstN (arstN),
        .run   (run),
        .instr (ir),
        .zero  (aluZero),
        .ctrl  (ctrl)
    );

    instrMemory imem_i (
        .clk   (clk),
        .we    (loadEn && !run),                   // Program load only while stopped
        .waddr (loadAddr),
        .wdata (loadData),
        .raddr (pc),
        .rdata (imemRdata)
    );

    registerFile regs_i (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (ir.rs1),
        .rs2   (ir.rs2),
        .rd    (ir.rd),
        .we    (ctrl.regWrite),
        .wd    (wbData),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    immGenerator immGen_i (
        .instr (ir),
        .kind  (ctrl.immKind),
        .imm   (imm)
    );

    // IR is not loaded yet during fetch, so the live PC is used there
    assign pcOperand = ctrl.irWrite ? pc : instrPc;
    assign aluA      = (ctrl.srcA == srcPc) ? pcOperand : opA;

    always_comb begin
        case (ctrl.srcB)
            srcImm:  aluB = imm;
            srcFour: aluB = xlen'(4);
            default: aluB = opB;
        endcase
    end

    aluUnit alu_i (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMemory dmem_i (
        .clk   (clk),
        .we    (ctrl.memWrite),
        .addr  (aluOut),
        .wdata (opB),
        .rdata (dmemRdata)
    );

    assign wbData = ctrl.memToReg ? dmemRdata : aluOut;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc          <= '0;
            decodeQ     <= 1'b0;
            executeQ    <= 1'b0;
            retireCount <= '0;
        end else begin
            decodeQ  <= ctrl.irWrite;              // Shadows the decode and execute states
            executeQ <= decodeQ;
            if (ctrl.pcWrite) begin
                pc <= ctrl.pcBranch ? aluOut : aluResult;
            end
            if (ctrl.retire) begin
                retireCount <= retireCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir      <= instrFieldsT'(imemRdata);
            instrPc <= pc;
        end
        if (decodeQ) begin
            opA <= rd1;
            opB <= rd2;
        end
        if (executeQ) begin
            aluOut <= aluResult;
        end
    end

    assign retireValid = ctrl.retire;

    always_comb begin
        retire.pc      = instrPc;
        retire.rd      = ctrl.regWrite ? ir.rd : '0;
        retire.data    = ctrl.regWrite ? wbData : '0;
        retire.count   = retireCount;              // Retires before this one
        retire.illegal = ctrl.illegal;
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import rvIsaPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic [regAddrW-1:0] rd,
    input  logic                we,
    input  logic [xlen-1:0]     wd,
    output logic [xlen-1:0]     rd1,
    output logic [xlen-1:0]     rd2
);

    logic [xlen-1:0] regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;                        // x0 stays zero
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

//--- source/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    localparam int xlen      = 32;
    localparam int imemWords = 64;
    localparam int dmemWords = 64;
    localparam int imemAddrW = $clog2(imemWords);
    localparam int dmemAddrW = $clog2(dmemWords);
    localparam int regCount  = 32;
    localparam int regAddrW  = 5;
    localparam int shamtW    = 5;                  // Shift amount bits of operand B

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        f3AddSub = 3'b000,
        f3Sll    = 3'b001,
        f3Slt    = 3'b010,
        f3Sltu   = 3'b011,
        f3Xor    = 3'b100,
        f3Srl    = 3'b101,                         // Also SRA, picked by funct7
        f3Or     = 3'b110,
        f3And    = 3'b111
    } funct3E;

    localparam funct3E f3Word = f3Slt;             // LW and SW width code
    localparam funct3E f3Beq  = f3AddSub;

    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000; // SUB and SRA/SRAI

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpE;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } instrFieldsT;

endpackage

`default_nettype wire

//--- test/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef struct packed {
    logic [xlen-1:0]     instr;
    logic [regAddrW-1:0] expRd;                    // Zero when nothing is written
    logic [xlen-1:0]     expData;
    logic                expIllegal;
    logic                skipNext;                 // Taken BEQ jumps over the next entry
} tableEntryT;

tableEntryT progTable [$];

function automatic logic [xlen-1:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic logic [xlen-1:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [xlen-1:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opStore};
endfunction

function automatic logic [xlen-1:0] encB(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3Beq, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
    return {{(xlen-12){v[11]}}, v};
endfunction

task automatic addEntry(input logic [xlen-1:0] instr, input logic [4:0] rd,
                        input logic [xlen-1:0] data, input logic illegal, input logic skip);
    tableEntryT entry;
    entry.instr      = instr;
    entry.expRd      = rd;
    entry.expData    = data;
    entry.expIllegal = illegal;
    entry.skipNext   = skip;
    progTable.push_back(entry);
endtask

// x1 holds a, x2 holds b; expected values follow the RV32I rules
task automatic buildProgram();
    logic [11:0]     immA;
    logic [11:0]     immB;
    logic [11:0]     immC;
    logic [4:0]      sh;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
    immA = 12'($random(seed)) & 12'h7ff;           // Positive, so a differs from b
    immB = 12'($random(seed)) | 12'h800;           // Negative
    immC = 12'($random(seed));
    sh   = 5'($random(seed));
    a    = sext12(immA);
    b    = sext12(immB);
    c    = sext12(immC);
    addEntry(encI(opImm, f3AddSub, 5'd1, 5'd0, immA), 5'd1, a, 1'b0, 1'b0);
    addEntry(encI(opImm, f3AddSub, 5'd2, 5'd0, immB), 5'd2, b, 1'b0, 1'b0);
    addEntry(encI(opImm, f3And, 5'd3, 5'd1, immC), 5'd3, a & c, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Or, 5'd4, 5'd1, immC), 5'd4, a | c, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Xor, 5'd5, 5'd2, immC), 5'd5, b ^ c, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Slt, 5'd6, 5'd2, immC), 5'd6,
             ($signed(b) < $signed(c)) ? 32'd1 : 32'd0, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Sltu, 5'd7, 5'd2, immC), 5'd7, (b < c) ? 32'd1 : 32'd0, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Sll, 5'd8, 5'd2, {7'h00, sh}), 5'd8, b << sh, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Srl, 5'd9, 5'd2, {7'h00, sh}), 5'd9, b >> sh, 1'b0, 1'b0);
    addEntry(encI(opImm, f3Srl, 5'd10, 5'd2, {7'h20, sh}), 5'd10, $signed(b) >>> sh, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd2, 5'd1, f3AddSub, 5'd11), 5'd11, a + b, 1'b0, 1'b0);
    addEntry(encR(7'h20, 5'd2, 5'd1, f3AddSub, 5'd12), 5'd12, a - b, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd2, 5'd1, f3And, 5'd13), 5'd13, a & b, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd2, 5'd1, f3Or, 5'd14), 5'd14, a | b, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd2, 5'd1, f3Xor, 5'd15), 5'd15, a ^ b, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd1, 5'd2, f3Slt, 5'd16), 5'd16,
             ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd1, 5'd2, f3Sltu, 5'd17), 5'd17, (b < a) ? 32'd1 : 32'd0, 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd2, 5'd1, f3Sll, 5'd18), 5'd18, a << b[4:0], 1'b0, 1'b0);
    addEntry(encR(7'h00, 5'd1, 5'd2, f3Srl, 5'd19), 5'd19, b >> a[4:0], 1'b0, 1'b0);
    addEntry(encR(7'h20, 5'd1, 5'd2, f3Srl, 5'd20), 5'd20, $signed(b) >>> a[4:0], 1'b0, 1'b0);
    addEntry(encI(opImm, f3AddSub, 5'd0, 5'd1, 12'h000), 5'd0, a, 1'b0, 1'b0); // Write to x0
    addEntry(encR(7'h00, 5'd0, 5'd0, f3Or, 5'd21), 5'd21, 32'd0, 1'b0, 1'b0);
    addEntry(encS(5'd1, 5'd0, 12'd16), 5'd0, 32'd0, 1'b0, 1'b0);
    addEntry(encS(5'd2, 5'd0, 12'd20), 5'd0, 32'd0, 1'b0, 1'b0);
    addEntry(encI(opLoad, f3Word, 5'd22, 5'd0, 12'd16), 5'd22, a, 1'b0, 1'b0);
    addEntry(encI(opLoad, f3Word, 5'd23, 5'd0, 12'd20), 5'd23, b, 1'b0, 1'b0);
    addEntry(encB(5'd1, 5'd1, 13'd8), 5'd0, 32'd0, 1'b0, 1'b1);   // Taken
    addEntry(encI(opImm, f3AddSub, 5'd24, 5'd0, 12'd1), 5'd24, 32'd1, 1'b0, 1'b0);
    addEntry(encB(5'd2, 5'd1, 13'd8), 5'd0, 32'd0, 1'b0, 1'b0);   // Falls through
    addEntry(encI(opImm, f3AddSub, 5'd25, 5'd0, 12'd5), 5'd25, 32'd5, 1'b0, 1'b0);
    addEntry({17'h0, 3'b000, 5'd1, 7'h7f}, 5'd0, 32'd0, 1'b1, 1'b0); // Unknown opcode
    addEntry(encI(opImm, f3AddSub, 5'd26, 5'd1, 12'h000), 5'd26, a, 1'b0, 1'b0);
endtask

`endif

//--- test/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
();

    localparam int resetCycles = 8;
    localparam int stopCycles  = 12;               // Quiet window after run drops

    logic                 clk = 1'b0;
    logic                 arstN;
    logic                 run;
    logic                 loadEn;
    logic [imemAddrW-1:0] loadAddr;
    logic [xlen-1:0]      loadData;
    logic                 retireValid;
    retireT               retire;

    int seed        = 62;
    int valueErrors = 0;
    int otherErrors = 0;
    int tableLen    = 0;

    `include "programTable.svh"

    multiCycleCore dut_i (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #2 clk = ~clk;

    task automatic reportMismatch(input string name, input logic [xlen-1:0] got,
                                  input logic [xlen-1:0] exp);
        $display("Error at %0d ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        valueErrors++;
    endtask

    // Count is left to checkCount
    task automatic checkRetire(input retireT got, input retireT exp);
        if (got.pc !== exp.pc) begin
            reportMismatch("retire.pc", got.pc, exp.pc);
        end
        if (got.rd !== exp.rd) begin
            reportMismatch("retire.rd", xlen'(got.rd), xlen'(exp.rd));
        end
        if (got.data !== exp.data) begin
            reportMismatch("retire.data", got.data, exp.data);
        end
        if (got.illegal !== exp.illegal) begin
            reportMismatch("retire.illegal", xlen'(got.illegal), xlen'(exp.illegal));
        end
    endtask

    task automatic checkCount(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            reportMismatch("retire.count", got, exp);
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < tableLen; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= imemAddrW'(i);
            loadData <= progTable[i].instr;
        end
        @(posedge clk);
        loadEn <= 1'b0;
        run    <= 1'b1;                            // Last word is written on this edge
    endtask

    task automatic waitRetire();
        do begin
            @(negedge clk);
        end while (!retireValid);
    endtask

    initial begin
        retireT expRet;
        int     expCount;
        logic   skipping;
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        expCount = 0;
        skipping = 1'b0;
        buildProgram();
        tableLen = progTable.size();
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        loadProgram();
        for (int i = 0; i < tableLen; i++) begin
            if (skipping) begin
                skipping = 1'b0;                   // Jumped over by the branch before
            end else begin
                waitRetire();
                expRet.pc      = xlen'(i * 4);
                expRet.rd      = progTable[i].expRd;
                expRet.data    = progTable[i].expData;
                expRet.count   = xlen'(expCount);
                expRet.illegal = progTable[i].expIllegal;
                checkRetire(retire, expRet);
                checkCount(retire.count, xlen'(expCount));
                expCount++;
                skipping = progTable[i].skipNext;
            end
        end
        @(posedge clk);
        run <= 1'b0;
        repeat (stopCycles) begin
            @(negedge clk);
            if (retireValid) begin
                $display("Retire seen at %0d ns after run was dropped", $time);
                otherErrors++;
            end
        end
        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Three times the four-cycle budget per entry, plus reset and load
    initial begin
        int limitCycles;
        wait (tableLen != 0);
        limitCycles = tableLen * 4 * 3 + tableLen + resetCycles + stopCycles + 4;
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: program did not finish within %0d cycles", limitCycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
